// ==== verilog/fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// instruction queue entries as a power of two
`define FETCH_QUEUE_DEPTH 8

// counter table indexed by addr[BP_INDEX_BITS+1:2]
`define BP_INDEX_BITS 6

// first fetch address out of reset
`define FETCH_RESET_ADDR 32'h0000_0000

`endif

// ==== verilog/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    // byte address of an instruction
    typedef logic [31:0] addr_t;

    // raw RV32I instruction word
    typedef logic [31:0] inst_t;

    // running instruction id that wraps around
    typedef logic [7:0] iid_t;

    // two-bit saturating counter
    // 0,1 not taken; 2,3 taken
    typedef logic [1:0] ctr_t;

    // one fetched instruction as stored in the queue
    typedef struct packed {
        addr_t addr;
        inst_t inst;
        iid_t  iid;
    } fetch_entry_t;

    // major opcodes the predecoder cares about
    localparam logic [6:0] jal_op    = 7'b1101111;
    localparam logic [6:0] branch_op = 7'b1100011;

endpackage

`default_nettype wire

// ==== verilog/fetch_entry_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// write path from fetch controller into the instruction queue
interface fetch_entry_if;
    logic                    valid;
    logic                    ready;
    logic                    almost_full;
    fetch_pkg::fetch_entry_t entry;

    modport producer (
        output valid,
        output entry,
        input  ready,
        input  almost_full
    );

    modport consumer (
        input  valid,
        input  entry,
        output ready,
        output almost_full
    );
endinterface

`default_nettype wire

// ==== verilog/inst_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_settings.svh"

module inst_queue (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    flush,
    fetch_entry_if.consumer         wr,
    output logic                    rd_valid,
    input  logic                    rd_ready,
    output fetch_pkg::fetch_entry_t rd_entry
);
    localparam int DEPTH = `FETCH_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    fetch_pkg::fetch_entry_t entries [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_fire;
    logic             rd_fire;

    assign wr.ready = (count != CNT_W'(DEPTH));
    assign wr_fire  = wr.valid && wr.ready;
    assign rd_valid = (count != '0);
    assign rd_fire  = rd_valid && rd_ready;
    assign rd_entry = entries[rd_ptr];

    // one slot or less left once this cycle's write lands
    assign wr.almost_full = (count + CNT_W'(wr_fire)) >= CNT_W'(DEPTH - 1);

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            entries[wr_ptr] <= wr.entry;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_fire, rd_fire})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/predecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module predecoder (
    input  fetch_pkg::inst_t inst,
    input  fetch_pkg::addr_t addr,
    output logic             is_jal,
    output logic             is_branch,
    output fetch_pkg::addr_t jal_target,
    output fetch_pkg::addr_t branch_target
);
    logic [6:0]       opcode;
    logic [19:0]      imm_j;
    logic [11:0]      imm_b;
    fetch_pkg::addr_t imm_j_sext;
    fetch_pkg::addr_t imm_b_sext;

    assign opcode = inst[6:0];

    assign is_jal    = (opcode == fetch_pkg::jal_op);
    assign is_branch = (opcode == fetch_pkg::branch_op);

    // J-type immediate bits 20:1 scattered over the word
    assign imm_j = {
        inst[31],
        inst[19:12],
        inst[20],
        inst[30:21]
    };

    // B-type immediate bits 12:1
    assign imm_b = {
        inst[31],
        inst[7],
        inst[30:25],
        inst[11:8]
    };

    assign imm_j_sext = {{11{imm_j[19]}}, imm_j, 1'b0};
    assign imm_b_sext = {{19{imm_b[11]}}, imm_b, 1'b0};

    assign jal_target    = addr + imm_j_sext;
    assign branch_target = addr + imm_b_sext;

endmodule

`default_nettype wire

// ==== verilog/branch_predictor.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_settings.svh"

module branch_predictor (
    input  logic             clk,
    input  logic             reset,
    input  fetch_pkg::addr_t lookup_addr,
    output logic             pred_taken,
    input  logic             update_valid,
    input  fetch_pkg::addr_t update_addr,
    input  logic             update_taken
);
    localparam int IDX_W   = `BP_INDEX_BITS;
    localparam int ENTRIES = 1 << IDX_W;

    fetch_pkg::ctr_t counters [ENTRIES];

    logic [IDX_W-1:0] lookup_idx;
    logic [IDX_W-1:0] update_idx;
    fetch_pkg::ctr_t  update_ctr;

    // word aligned, so skip the low two bits
    assign lookup_idx = lookup_addr[IDX_W+1:2];
    assign update_idx = update_addr[IDX_W+1:2];

    // msb of the counter is the prediction
    assign pred_taken = counters[lookup_idx][1];

    assign update_ctr = counters[update_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            // weakly not taken
            for (int i = 0; i < ENTRIES; i++) begin
                counters[i] <= 2'd1;
            end
        end else if (update_valid) begin
            if (update_taken) begin
                if (update_ctr != 2'd3) begin
                    counters[update_idx] <= update_ctr + 2'd1;
                end
            end else begin
                if (update_ctr != 2'd0) begin
                    counters[update_idx] <= update_ctr - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fetch_control.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_settings.svh"

module fetch_control (
    input  logic             clk,
    input  logic             reset,
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_addr,
    output logic             mem_req_valid,
    input  logic             mem_req_ready,
    output fetch_pkg::addr_t mem_req_addr,
    input  logic             mem_resp_valid,
    input  fetch_pkg::inst_t mem_resp_data,
    fetch_entry_if.producer  q,
    output logic             flush,
    output fetch_pkg::addr_t lookup_addr,
    input  logic             pred_taken,
    input  logic             is_jal,
    input  logic             is_branch,
    input  fetch_pkg::addr_t jal_target,
    input  fetch_pkg::addr_t branch_target
);
    fetch_pkg::addr_t fetch_addr;
    fetch_pkg::addr_t next_addr;
    fetch_pkg::iid_t  iid;

    logic running;
    logic outstanding;
    logic discard;
    logic req_fire;
    logic resp_seen;
    logic resp_take;

    // fetch_addr stays on the outstanding request until its response
    assign mem_req_addr = fetch_addr;
    assign lookup_addr  = fetch_addr;

    // one request at a time, and only if the queue can still take it
    assign mem_req_valid = running && !outstanding && !q.almost_full;
    assign req_fire      = mem_req_valid && mem_req_ready;

    assign resp_seen = outstanding && mem_resp_valid;
    // a redirect in the response cycle kills that word too
    assign resp_take = resp_seen && !discard && !redirect_valid;

    assign flush = redirect_valid;

    assign q.valid = resp_take;
    assign q.entry = '{addr: fetch_addr, inst: mem_resp_data, iid: iid};

    always_comb begin
        if (is_jal) begin
            next_addr = jal_target;
        end else if (is_branch && pred_taken) begin
            next_addr = branch_target;
        end else begin
            next_addr = fetch_addr + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            running     <= 1'b0;
            outstanding <= 1'b0;
            discard     <= 1'b0;
            iid         <= '0;
            fetch_addr  <= `FETCH_RESET_ADDR;
        end else begin
            running <= 1'b1;

            if (resp_seen) begin
                outstanding <= 1'b0;
            end else if (req_fire) begin
                outstanding <= 1'b1;
            end

            // response still owed to an old path is dropped on arrival
            if (resp_seen) begin
                discard <= 1'b0;
            end
            if (redirect_valid && (req_fire || (outstanding && !mem_resp_valid))) begin
                discard <= 1'b1;
            end

            if (redirect_valid) begin
                fetch_addr <= redirect_addr;
            end else if (resp_take) begin
                fetch_addr <= next_addr;
            end

            // ids keep counting across redirects
            if (resp_take) begin
                iid <= iid + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/inst_fetch_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_fetch_top (
    input  logic             clk,
    input  logic             reset,
    output logic             mem_req_valid,
    input  logic             mem_req_ready,
    output fetch_pkg::addr_t mem_req_addr,
    input  logic             mem_resp_valid,
    input  fetch_pkg::inst_t mem_resp_data,
    output logic             inst_valid,
    input  logic             inst_ready,
    output fetch_pkg::addr_t inst_addr,
    output fetch_pkg::inst_t inst_data,
    output fetch_pkg::iid_t  inst_id,
    input  logic             redirect_valid,
    input  fetch_pkg::addr_t redirect_addr,
    input  logic             bp_update_valid,
    input  fetch_pkg::addr_t bp_update_addr,
    input  logic             bp_update_taken
);
    logic                    flush;
    logic                    pred_taken;
    logic                    is_jal;
    logic                    is_branch;
    fetch_pkg::addr_t        lookup_addr;
    fetch_pkg::addr_t        jal_target;
    fetch_pkg::addr_t        branch_target;
    fetch_pkg::fetch_entry_t rd_entry;

    fetch_entry_if q_if ();

    fetch_control u_fetch_control (
        .clk            (clk),
        .reset          (reset),
        .redirect_valid (redirect_valid),
        .redirect_addr  (redirect_addr),
        .mem_req_valid  (mem_req_valid),
        .mem_req_ready  (mem_req_ready),
        .mem_req_addr   (mem_req_addr),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .q              (q_if),
        .flush          (flush),
        .lookup_addr    (lookup_addr),
        .pred_taken     (pred_taken),
        .is_jal         (is_jal),
        .is_branch      (is_branch),
        .jal_target     (jal_target),
        .branch_target  (branch_target)
    );

    // both look at the returned word side by side
    predecoder u_predecoder (
        .inst          (mem_resp_data),
        .addr          (lookup_addr),
        .is_jal        (is_jal),
        .is_branch     (is_branch),
        .jal_target    (jal_target),
        .branch_target (branch_target)
    );

    branch_predictor u_branch_predictor (
        .clk          (clk),
        .reset        (reset),
        .lookup_addr  (lookup_addr),
        .pred_taken   (pred_taken),
        .update_valid (bp_update_valid),
        .update_addr  (bp_update_addr),
        .update_taken (bp_update_taken)
    );

    inst_queue u_inst_queue (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .wr       (q_if),
        .rd_valid (inst_valid),
        .rd_ready (inst_ready),
        .rd_entry (rd_entry)
    );

    assign inst_addr = rd_entry.addr;
    assign inst_data = rd_entry.inst;
    assign inst_id   = rd_entry.iid;

endmodule

`default_nettype wire

// ==== verification/inst_fetch_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module inst_fetch_assertions (
    input logic             clk,
    input logic             reset,
    input logic             mem_req_valid,
    input logic             mem_req_ready,
    input logic             mem_resp_valid,
    input logic             inst_valid,
    input logic             inst_ready,
    input fetch_pkg::inst_t inst_data,
    input logic             redirect_valid,
    input logic             q_valid,
    input logic             q_ready
);
    int   error_count = 0;
    logic waiting;

    // request accepted and response not back yet
    always_ff @(posedge clk) begin
        if (reset || mem_resp_valid) begin
            waiting <= 1'b0;
        end else if (mem_req_valid && mem_req_ready) begin
            waiting <= 1'b1;
        end
    end

    data_held: assert property (@(posedge clk) disable iff (reset)
        inst_valid && !inst_ready && !redirect_valid |=> inst_valid && $stable(inst_data))
    else begin
        $error("inst_data changed while the back end stalled");
        error_count++;
    end

    req_held: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid)
    else begin
        $error("mem_req_valid dropped before the request was accepted");
        error_count++;
    end

    single_req: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && mem_req_ready |-> !waiting)
    else begin
        $error("second request accepted before the response");
        error_count++;
    end

    // a response never meets a full queue
    queue_slot: assert property (@(posedge clk) disable iff (reset) q_valid |-> q_ready)
    else begin
        $error("queue write while the queue was full");
        error_count++;
    end

endmodule

bind inst_fetch_top inst_fetch_assertions u_assertions (
    .clk            (clk),
    .reset          (reset),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_resp_valid (mem_resp_valid),
    .inst_valid     (inst_valid),
    .inst_ready     (inst_ready),
    .inst_data      (inst_data),
    .redirect_valid (redirect_valid),
    .q_valid        (q_if.valid),
    .q_ready        (q_if.ready)
);

`default_nettype wire

// ==== verification/inst_fetch_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_settings.svh"

module inst_fetch_tb;
    localparam int bp_entries    = 1 << `BP_INDEX_BITS;
    localparam int max_latency   = 4;
    localparam int n_straight    = 12;
    localparam int n_jal         = 10;
    localparam int n_branch      = 8;
    localparam int n_redirect    = 10;
    localparam int n_stall       = 24;
    localparam int total_fetches = n_straight + n_jal + 3 * n_branch + n_redirect + n_stall;
    localparam int cycle_limit   = 10 * total_fetches * max_latency;

    logic             clk;
    logic             reset = 1'b1;
    logic             mem_req_valid;
    logic             mem_req_ready = 1'b0;
    fetch_pkg::addr_t mem_req_addr;
    logic             mem_resp_valid = 1'b0;
    fetch_pkg::inst_t mem_resp_data = '0;
    logic             inst_valid;
    logic             inst_ready = 1'b0;
    fetch_pkg::addr_t inst_addr;
    fetch_pkg::inst_t inst_data;
    fetch_pkg::iid_t  inst_id;
    logic             redirect_valid = 1'b0;
    fetch_pkg::addr_t redirect_addr = '0;
    logic             bp_update_valid = 1'b0;
    fetch_pkg::addr_t bp_update_addr = '0;
    logic             bp_update_taken = 1'b0;

    fetch_pkg::inst_t prog [1024];
    fetch_pkg::ctr_t  tb_ctrs [bp_entries];
    fetch_pkg::addr_t exp_addr_q [$];
    fetch_pkg::inst_t exp_inst_q [$];

    // memory model state
    fetch_pkg::addr_t resp_addr = '0;
    int               wait_left = 0;
    logic             in_flight = 1'b0;
    logic             killed = 1'b0;
    fetch_pkg::iid_t  taken_count = '0;
    fetch_pkg::iid_t  id_base = '0;

    string test_name = "reset";
    logic  active = 1'b0;
    int    ready_mode = 0;
    int    stretch = 0;
    int    checked = 0;
    int    checks_total = 0;
    int    test_errors = 0;
    int    errors = 0;
    int    tests_run = 0;
    int    cycle_count = 0;
    int    total_errors;

    inst_fetch_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // addi with an immediate taken from the word index
    function automatic fetch_pkg::inst_t fill_word(input int index);
        return {index[9:0], 2'b01, 5'd3, 3'b000, 5'd3, 7'b0010011};
    endfunction

    function automatic fetch_pkg::inst_t encode_jal(input int offset);
        logic [20:0] imm;
        imm = offset[20:0];
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, fetch_pkg::jal_op};
    endfunction

    function automatic fetch_pkg::inst_t encode_beq(input int offset);
        logic [12:0] imm;
        imm = offset[12:0];
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], fetch_pkg::branch_op};
    endfunction

    function automatic fetch_pkg::addr_t expected_next(input fetch_pkg::addr_t addr,
                                                       input fetch_pkg::inst_t word,
                                                       input fetch_pkg::ctr_t ctrs [bp_entries]);
        int offset;
        if (word[6:0] == fetch_pkg::jal_op) begin
            offset = $signed({word[31], word[19:12], word[20], word[30:21], 1'b0});
            return addr + offset;
        end
        if (word[6:0] == fetch_pkg::branch_op && ctrs[addr[`BP_INDEX_BITS+1:2]] >= 2'd2) begin
            offset = $signed({word[31], word[7], word[30:25], word[11:8], 1'b0});
            return addr + offset;
        end
        return addr + 32'd4;
    endfunction

    task automatic check_addr(input fetch_pkg::addr_t expected, input fetch_pkg::addr_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s inst_addr: expected %h, actual %h", test_name, expected, actual);
            test_errors++;
            errors++;
        end
    endtask

    task automatic check_inst(input fetch_pkg::inst_t expected, input fetch_pkg::inst_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s inst_data: expected %h, actual %h", test_name, expected, actual);
            test_errors++;
            errors++;
        end
    endtask

    task automatic check_id(input fetch_pkg::iid_t expected, input fetch_pkg::iid_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s inst_id: expected %0d, actual %0d", test_name, expected, actual);
            test_errors++;
            errors++;
        end
    endtask

    task automatic send_update(input fetch_pkg::addr_t addr, input logic taken);
        int idx;
        idx = addr[`BP_INDEX_BITS+1:2];
        @(posedge clk);
        bp_update_valid <= 1'b1;
        bp_update_addr  <= addr;
        bp_update_taken <= taken;
        @(posedge clk);
        bp_update_valid <= 1'b0;
        if (taken && tb_ctrs[idx] != 2'd3) begin
            tb_ctrs[idx] = tb_ctrs[idx] + 2'd1;
        end else if (!taken && tb_ctrs[idx] != 2'd0) begin
            tb_ctrs[idx] = tb_ctrs[idx] - 2'd1;
        end
    endtask

    task automatic run_test(input string name, input fetch_pkg::addr_t start, input int n,
                            input int mode, input bit redirect, input bit in_flight_first);
        fetch_pkg::addr_t a;
        if (redirect) begin
            if (in_flight_first) begin
                ready_mode <= 1;
                // redirect lands before the owed response comes back
                do @(posedge clk); while (!in_flight || wait_left == 0);
            end else begin
                @(posedge clk);
            end
            redirect_valid <= 1'b1;
            redirect_addr  <= start;
            ready_mode     <= 0;
            @(posedge clk);
            redirect_valid <= 1'b0;
        end
        test_name   = name;
        test_errors = 0;
        a = start;
        for (int i = 0; i < n; i++) begin
            exp_addr_q.push_back(a);
            exp_inst_q.push_back(prog[a[11:2]]);
            a = expected_next(a, prog[a[11:2]], tb_ctrs);
        end
        checked    <= 0;
        active     <= 1'b1;
        ready_mode <= mode;
        if (redirect) begin
            @(posedge clk);
            if (inst_valid) begin
                $display("%s: queue still holds entries after the redirect", name);
                test_errors++;
                errors++;
            end
        end
        do @(posedge clk); while (checked < n);
        ready_mode <= 0;
        active     <= 1'b0;
        tests_run++;
        $display("test %s done: %0d entries, %0d errors", name, n, test_errors);
    endtask

    // one request at a time with latency of 1 to 4 cycles
    always @(posedge clk) begin : memory_model
        int lat;
        if (reset) begin
            mem_req_ready  <= 1'b0;
            mem_resp_valid <= 1'b0;
            in_flight      <= 1'b0;
            wait_left      <= 0;
            taken_count    <= '0;
            id_base        <= '0;
        end else begin
            mem_req_ready  <= ($urandom_range(3, 0) != 0);
            mem_resp_valid <= 1'b0;
            // dropped if a redirect came at any edge since the request
            if (mem_resp_valid) begin
                in_flight <= 1'b0;
                if (!killed && !redirect_valid) begin
                    taken_count <= taken_count + 1'b1;
                end
            end
            if (redirect_valid) begin
                id_base <= taken_count;
            end
            if (mem_req_valid && mem_req_ready) begin
                lat = $urandom_range(max_latency, 1);
                in_flight <= 1'b1;
                killed    <= redirect_valid;
                resp_addr <= mem_req_addr;
                wait_left <= lat - 1;
                if (lat == 1) begin
                    mem_resp_valid <= 1'b1;
                    mem_resp_data  <= prog[mem_req_addr[11:2]];
                end
            end else begin
                if (redirect_valid) begin
                    killed <= 1'b1;
                end
                if (wait_left != 0) begin
                    wait_left <= wait_left - 1;
                    if (wait_left == 1) begin
                        mem_resp_valid <= 1'b1;
                        mem_resp_data  <= prog[resp_addr[11:2]];
                    end
                end
            end
        end
    end

    // back end ready is off, on, or toggled in long random stretches
    always @(posedge clk) begin
        case (ready_mode)
            0: inst_ready <= 1'b0;
            1: inst_ready <= 1'b1;
            default: begin
                if (stretch == 0) begin
                    inst_ready <= !inst_ready;
                    stretch    <= $urandom_range(30, 10);
                end else begin
                    stretch <= stretch - 1;
                end
            end
        endcase
    end

    always @(posedge clk) begin
        if (active && inst_valid && inst_ready && exp_addr_q.size() != 0) begin
            check_addr(exp_addr_q.pop_front(), inst_addr);
            check_inst(exp_inst_q.pop_front(), inst_data);
            check_id(fetch_pkg::iid_t'(id_base + checked), inst_id);
            checked <= checked + 1;
            checks_total++;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == cycle_limit) begin
            $display("timeout: tests did not finish within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h544f_d458));
        for (int i = 0; i < 1024; i++) begin
            prog[i] = fill_word(i);
        end
        prog[32'h100 >> 2] = encode_jal(32'h40);
        prog[32'h14c >> 2] = encode_jal(-60);
        prog[32'h200 >> 2] = encode_beq(32);
        for (int i = 0; i < bp_entries; i++) begin
            tb_ctrs[i] = 2'd1;
        end
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        run_test("straight", `FETCH_RESET_ADDR, n_straight, 1, 1'b0, 1'b0);
        run_test("jal", 32'h0f8, n_jal, 1, 1'b1, 1'b0);
        run_test("branch_cold", 32'h1f8, n_branch, 1, 1'b1, 1'b0);
        send_update(32'h200, 1'b1);
        run_test("branch_trained", 32'h1f8, n_branch, 1, 1'b1, 1'b0);
        send_update(32'h200, 1'b0);
        send_update(32'h200, 1'b0);
        run_test("branch_untrained", 32'h1f8, n_branch, 1, 1'b1, 1'b0);
        run_test("redirect_in_flight", 32'h384, n_redirect, 1, 1'b1, 1'b1);
        run_test("stall", 32'h0f8, n_stall, 2, 1'b1, 1'b0);

        total_errors = errors + uut.u_assertions.error_count;
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks_total, total_errors);
        if (total_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verilog
verilog/fetch_pkg.sv
verilog/fetch_entry_if.sv
verilog/inst_queue.sv
verilog/predecoder.sv
verilog/branch_predictor.sv
verilog/fetch_control.sv
verilog/inst_fetch_top.sv
verification/inst_fetch_assertions.sv
verification/inst_fetch_tb.sv

// ==== Bender.yml ====
package:
  name: inst_fetch

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/fetch_pkg.sv
      - verilog/fetch_entry_if.sv
      - verilog/inst_queue.sv
      - verilog/predecoder.sv
      - verilog/branch_predictor.sv
      - verilog/fetch_control.sv
      - verilog/inst_fetch_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/inst_fetch_assertions.sv
      - verification/inst_fetch_tb.sv
